/* design/devTlbPkg.sv */
// Device TLB invalidation types
package devTlbPkg;

    // ========================================
    // Field widths
    // ========================================
    typedef logic [19:0] pasidT;    // Process address space ID
    typedef logic [15:0] bdfT;      // Bus/device/function requester ID
    typedef logic [19:0] vpnT;      // Virtual page number
    typedef logic [23:0] ppnT;      // Physical page number

    // Traffic class mask returned by the host unit, one bit per class
    typedef logic [7:0]  tcT;

    // ========================================
    // Register access
    // ========================================
    typedef logic [1:0]  regAddrT;  // Four registers
    typedef logic [31:0] regDataT;

    // ========================================
    // Drain FSM
    // ========================================
    // Idle until an invalidation is accepted with draining enabled,
    // armed until the walk reaches its tail, then the request/ack and
    // response phases toward the host unit
    typedef enum logic [1:0] {
        DrainIdle,  // Nothing outstanding
        DrainArm,   // Walk in progress
        DrainReq,   // Request held until ack
        DrainRsp    // Ack seen, waiting for response
    } drainStateT;

endpackage

/* design/tlbCache.sv */
// Device TLB entry array
// Fill, lookup and sequential invalidation walk
module tlbCache #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic             clk,
    input  logic             arstN,
    // Fill group
    input  logic             fillValid,
    input  devTlbPkg::pasidT fillPasid,
    input  devTlbPkg::bdfT   fillBdf,
    input  devTlbPkg::vpnT   fillVpn,
    input  devTlbPkg::ppnT   fillPpn,
    input  logic             fillGlobal,
    // Lookup group
    input  logic             lookupValid,
    input  devTlbPkg::pasidT lookupPasid,
    input  devTlbPkg::bdfT   lookupBdf,
    input  devTlbPkg::vpnT   lookupVpn,
    output logic             lookupDone,
    output logic             lookupHit,
    output devTlbPkg::ppnT   lookupPpn,
    // Invalidation key
    input  logic             invAccept,
    input  devTlbPkg::pasidT invPasid,
    input  logic             invPasidValid,
    input  logic             invGlobal,
    input  devTlbPkg::bdfT   invBdf,
    input  logic             invBdfValid,
    output logic             walkBusy,
    output logic             invTail     // Last entry under check
);
    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_ENTRIES - 1);

    logic [NUM_ENTRIES-1:0] entValid;
    logic [NUM_ENTRIES-1:0] entGlobal;
    devTlbPkg::pasidT       entPasid [NUM_ENTRIES];
    devTlbPkg::bdfT         entBdf   [NUM_ENTRIES];
    devTlbPkg::vpnT         entVpn   [NUM_ENTRIES];
    devTlbPkg::ppnT         entPpn   [NUM_ENTRIES];

    logic [IDX_W-1:0] victimPtr;  // Round-robin fill slot
    logic [IDX_W-1:0] walkPtr;

    // Latched invalidation key
    devTlbPkg::pasidT keyPasid;
    devTlbPkg::bdfT   keyBdf;
    logic             keyPasidValid;
    logic             keyGlobal;
    logic             keyBdfValid;

    logic             pasidEq;
    logic             pasidOk;
    logic             bdfOk;
    logic             walkMatch;
    logic             hitAny;
    devTlbPkg::ppnT   hitPpn;

    // ========================================
    // Entry storage
    // ========================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entValid <= '0;
        end else begin
            if (fillValid) entValid[victimPtr] <= 1'b1;
            if (walkMatch) entValid[walkPtr] <= 1'b0;  // Never same cycle as a fill
        end
    end

    always_ff @(posedge clk) begin
        if (fillValid) begin
            entGlobal[victimPtr] <= fillGlobal;
            entPasid[victimPtr]  <= fillPasid;
            entBdf[victimPtr]    <= fillBdf;
            entVpn[victimPtr]    <= fillVpn;
            entPpn[victimPtr]    <= fillPpn;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            victimPtr <= '0;
        end else if (fillValid) begin
            victimPtr <= (victimPtr == LAST_IDX) ? '0 : victimPtr + 1'b1;  // Wrap
        end
    end

    // ========================================
    // Lookup, one cycle
    // ========================================
    always_comb begin
        hitAny = 1'b0;
        hitPpn = '0;
        // Lowest index wins on a double hit
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (entValid[i] && entVpn[i] == lookupVpn && entBdf[i] == lookupBdf &&
                (entGlobal[i] || entPasid[i] == lookupPasid)) begin
                hitAny = 1'b1;
                hitPpn = entPpn[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lookupDone <= 1'b0;
            lookupHit  <= 1'b0;
        end else begin
            lookupDone <= lookupValid;
            lookupHit  <= lookupValid && hitAny;
        end
    end

    always_ff @(posedge clk) begin
        if (lookupValid) lookupPpn <= hitPpn;
    end

    // ========================================
    // Invalidation walk
    // ========================================
    always_ff @(posedge clk) begin
        if (invAccept) begin
            keyPasid      <= invPasid;
            keyPasidValid <= invPasidValid;
            keyGlobal     <= invGlobal;
            keyBdf        <= invBdf;
            keyBdfValid   <= invBdfValid;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            walkBusy <= 1'b0;
            walkPtr  <= '0;
        end else if (invAccept) begin
            walkBusy <= 1'b1;
            walkPtr  <= '0;
        end else if (walkBusy) begin
            walkBusy <= !invTail;  // Done after last entry
            walkPtr  <= walkPtr + 1'b1;
        end
    end

    always_comb begin
        pasidEq = entPasid[walkPtr] == keyPasid;
        bdfOk   = !keyBdfValid || entBdf[walkPtr] == keyBdf;
        // Global entry of another PASID goes only with invGlobal
        pasidOk = entGlobal[walkPtr] ? (pasidEq || keyGlobal) : (pasidEq || !keyPasidValid);
        walkMatch = walkBusy && entValid[walkPtr] && bdfOk && pasidOk;
    end

    assign invTail = walkBusy && walkPtr == LAST_IDX;

    // Fills are held off by the shared busy level at the top
    fillDuringWalk: assert property (@(posedge clk) disable iff (!arstN)
        fillValid |-> !walkBusy);

    // Tail arrives exactly NUM_ENTRIES cycles into the walk
    tailAtWalkEnd: assert property (@(posedge clk) disable iff (!arstN)
        $rose(walkBusy) |-> ##(NUM_ENTRIES - 1) invTail ##1 !walkBusy);

endmodule

/* design/invDrain.sv */
// Invalidation drain request logic
module invDrain (
    input  logic             clk,
    input  logic             arstN,
    input  logic             invAccept,
    input  devTlbPkg::pasidT invPasid,
    input  logic             invPasidValid,
    input  logic             invGlobal,
    input  logic             invPriv,
    input  devTlbPkg::bdfT   invBdf,
    input  logic             invBdfValid,
    input  logic             drainEn,       // Sampled at accept
    input  logic             invTail,
    output logic             drainBusy,
    // Host unit drain port
    output logic             drainReqValid,
    output devTlbPkg::pasidT drainReqPasid,
    output logic             drainReqPasidValid,
    output logic             drainReqPriv,
    output logic             drainReqGlobal,
    output devTlbPkg::bdfT   drainReqBdf,
    output logic             drainReqBdfValid,
    input  logic             drainReqAck,   // Pulse
    input  logic             drainRspValid, // Pulse with or after ack
    output logic             drainDone
);
    devTlbPkg::drainStateT drainState;
    devTlbPkg::drainStateT drainNext;
    logic                  reqValidNext;

    // ========================================
    // Drain FSM
    // ========================================
    always_comb begin
        drainNext    = drainState;
        reqValidNext = drainReqValid;
        drainDone    = 1'b0;
        case (drainState)
            devTlbPkg::DrainIdle: begin
                if (invAccept && drainEn) drainNext = devTlbPkg::DrainArm;
            end
            devTlbPkg::DrainArm: begin
                if (invTail) begin   // Walk finished
                    drainNext    = devTlbPkg::DrainReq;
                    reqValidNext = 1'b1;
                end
            end
            devTlbPkg::DrainReq: begin
                if (drainReqAck) begin
                    reqValidNext = 1'b0;
                    drainNext    = devTlbPkg::DrainRsp;
                    if (drainRspValid) begin  // Response together with ack
                        drainNext = devTlbPkg::DrainIdle;
                        drainDone = 1'b1;
                    end
                end
            end
            devTlbPkg::DrainRsp: begin
                if (drainRspValid) begin
                    drainNext = devTlbPkg::DrainIdle;
                    drainDone = 1'b1;
                end
            end
            default: drainNext = devTlbPkg::DrainIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            drainState    <= devTlbPkg::DrainIdle;
            drainReqValid <= 1'b0;
        end else begin
            drainState    <= drainNext;
            drainReqValid <= reqValidNext;
        end
    end

    assign drainBusy = drainState != devTlbPkg::DrainIdle;

    // ========================================
    // Request field capture
    // ========================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            drainReqPasidValid <= 1'b0;
            drainReqBdfValid   <= 1'b0;
        end else if (invAccept) begin
            drainReqPasidValid <= invPasidValid;
            drainReqBdfValid   <= invBdfValid;
        end
    end

    always_ff @(posedge clk) begin
        if (invAccept) begin
            drainReqPasid  <= invPasid;
            drainReqPriv   <= invPriv;
            drainReqGlobal <= invGlobal;
            drainReqBdf    <= invBdfValid ? invBdf : '0;  // No stale BDF to host
        end
    end

    // Request level and fields hold under back-pressure until the host acks
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
        drainReqValid && !drainReqAck |=> drainReqValid &&
            $stable({drainReqPasid, drainReqPasidValid, drainReqPriv, drainReqGlobal,
                     drainReqBdf, drainReqBdfValid}));

    // Host only acks a request the FSM is presenting
    ackOnlyInReq: assert property (@(posedge clk) disable iff (!arstN)
        drainReqAck |-> drainState == devTlbPkg::DrainReq);

endmodule

/* design/invCtrlRegs.sv */
// Invalidation control and status registers
module invCtrlRegs (
    input  logic                clk,
    input  logic                arstN,
    input  logic                regWrEn,
    input  devTlbPkg::regAddrT  regAddr,
    input  devTlbPkg::regDataT  regWrData,
    input  logic                invTail,     // One per invalidation
    input  logic                drainDone,   // One per completed drain
    input  devTlbPkg::tcT       drainRspTc,
    output logic                drainEn,
    output devTlbPkg::regDataT  regRdData
);
    // Register indexes
    localparam devTlbPkg::regAddrT REG_CTRL      = 2'd0;
    localparam devTlbPkg::regAddrT REG_INV_CNT   = 2'd1;
    localparam devTlbPkg::regAddrT REG_DRAIN_CNT = 2'd2;
    localparam devTlbPkg::regAddrT REG_LAST_TC   = 2'd3;

    devTlbPkg::regDataT invCount;
    devTlbPkg::regDataT drainCount;
    devTlbPkg::tcT      lastTc;

    // ========================================
    // Control and counters
    // ========================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            drainEn <= 1'b1;  // Draining on by default
        end else if (regWrEn && regAddr == REG_CTRL) begin
            drainEn <= regWrData[0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            invCount   <= '0;
            drainCount <= '0;
            lastTc     <= '0;
        end else begin
            if (invTail) invCount <= invCount + 1'b1;
            if (drainDone) begin
                drainCount <= drainCount + 1'b1;
                lastTc     <= drainRspTc;  // TC of latest response
            end
        end
    end

    // Read mux, no side effects
    always_comb begin
        case (regAddr)
            REG_CTRL:      regRdData = devTlbPkg::regDataT'(drainEn);
            REG_INV_CNT:   regRdData = invCount;
            REG_DRAIN_CNT: regRdData = drainCount;
            REG_LAST_TC:   regRdData = devTlbPkg::regDataT'(lastTc);
            default:       regRdData = '0;
        endcase
    end

endmodule

/* design/devTlbInv.sv */
// Device TLB invalidation subsystem top
module devTlbInv #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic               clk,
    input  logic               arstN,
    // Fill
    input  logic               fillValid,
    input  devTlbPkg::pasidT   fillPasid,
    input  devTlbPkg::bdfT     fillBdf,
    input  devTlbPkg::vpnT     fillVpn,
    input  devTlbPkg::ppnT     fillPpn,
    input  logic               fillGlobal,
    // Lookup
    input  logic               lookupValid,
    input  devTlbPkg::pasidT   lookupPasid,
    input  devTlbPkg::bdfT     lookupBdf,
    input  devTlbPkg::vpnT     lookupVpn,
    output logic               lookupDone,
    output logic               lookupHit,
    output devTlbPkg::ppnT     lookupPpn,
    // Invalidation request
    input  logic               invValid,
    input  devTlbPkg::pasidT   invPasid,
    input  logic               invPasidValid,
    input  logic               invGlobal,
    input  logic               invPriv,
    input  devTlbPkg::bdfT     invBdf,
    input  logic               invBdfValid,
    output logic               invBusy,
    // Drain toward host unit
    output logic               drainReqValid,
    output devTlbPkg::pasidT   drainReqPasid,
    output logic               drainReqPasidValid,
    output logic               drainReqPriv,
    output logic               drainReqGlobal,
    output devTlbPkg::bdfT     drainReqBdf,
    output logic               drainReqBdfValid,
    input  logic               drainReqAck,
    input  logic               drainRspValid,
    input  devTlbPkg::tcT      drainRspTc,
    // Registers
    input  logic               regWrEn,
    input  devTlbPkg::regAddrT regAddr,
    input  devTlbPkg::regDataT regWrData,
    output devTlbPkg::regDataT regRdData
);
    logic invAccept;
    logic invTail;
    logic walkBusy;
    logic drainBusy;
    logic drainDone;
    logic drainEn;

    assign invAccept = invValid && !invBusy;  // Dropped while busy
    assign invBusy   = walkBusy || drainBusy;

    tlbCache #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) tlbCache_i (
        .clk, .arstN,
        .fillValid, .fillPasid, .fillBdf, .fillVpn, .fillPpn, .fillGlobal,
        .lookupValid, .lookupPasid, .lookupBdf, .lookupVpn,
        .lookupDone, .lookupHit, .lookupPpn,
        .invAccept, .invPasid, .invPasidValid, .invGlobal, .invBdf, .invBdfValid,
        .walkBusy, .invTail
    );

    invDrain invDrain_i (
        .clk, .arstN,
        .invAccept, .invPasid, .invPasidValid, .invGlobal, .invPriv,
        .invBdf, .invBdfValid, .drainEn, .invTail, .drainBusy,
        .drainReqValid, .drainReqPasid, .drainReqPasidValid, .drainReqPriv,
        .drainReqGlobal, .drainReqBdf, .drainReqBdfValid,
        .drainReqAck, .drainRspValid, .drainDone
    );

    invCtrlRegs invCtrlRegs_i (
        .clk, .arstN,
        .regWrEn, .regAddr, .regWrData,
        .invTail, .drainDone, .drainRspTc,
        .drainEn, .regRdData
    );

endmodule

/* verif/devTlbInvTb.sv */
// Device TLB invalidation testbench
module devTlbInvTb;
    localparam int NUM_ENTRIES = 8;
    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 5;
    localparam devTlbPkg::bdfT BDF_A = 16'h0100;
    localparam devTlbPkg::bdfT BDF_B = 16'h0208;

    logic clk;
    logic arstN;
    logic fillValid, fillGlobal, lookupValid, lookupDone, lookupHit;
    devTlbPkg::pasidT fillPasid, lookupPasid, invPasid, drainReqPasid;
    devTlbPkg::bdfT   fillBdf, lookupBdf, invBdf, drainReqBdf;
    devTlbPkg::vpnT   fillVpn, lookupVpn;
    devTlbPkg::ppnT   fillPpn, lookupPpn;
    logic invValid, invPasidValid, invGlobal, invPriv, invBdfValid, invBusy;
    logic drainReqValid, drainReqPasidValid, drainReqPriv, drainReqGlobal, drainReqBdfValid;
    logic drainReqAck, drainRspValid;
    devTlbPkg::tcT      drainRspTc;
    logic               regWrEn;
    devTlbPkg::regAddrT regAddr;
    devTlbPkg::regDataT regWrData, regRdData;

    // Expected entry array
    logic             mValid  [NUM_ENTRIES];
    logic             mGlobal [NUM_ENTRIES];
    devTlbPkg::pasidT mPasid  [NUM_ENTRIES];
    devTlbPkg::bdfT   mBdf    [NUM_ENTRIES];
    devTlbPkg::vpnT   mVpn    [NUM_ENTRIES];
    devTlbPkg::ppnT   mPpn    [NUM_ENTRIES];
    int               mVictim;       // Round-robin slot
    int               seed;
    int               invIssued;
    int               drainIssued;
    devTlbPkg::tcT    lastTcExp;
    devTlbPkg::pasidT pasA, pasB;

    devTlbInv #(.NUM_ENTRIES(NUM_ENTRIES)) devTlbInv_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Watchdog allows 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        abortRun("Run timed out before all tests finished");
    end

    // ========================================
    // Checks
    // ========================================
    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) abortRun($sformatf("FAILED at %0t: %s expected %b, got %b",
            $time, name, exp, act));
    endtask

    task automatic checkPpn(input string name, input devTlbPkg::ppnT exp,
                            input devTlbPkg::ppnT act);
        if (act !== exp) abortRun($sformatf("FAILED at %0t: %s expected %h, got %h",
            $time, name, exp, act));
    endtask

    task automatic checkPasid(input string name, input devTlbPkg::pasidT exp,
                              input devTlbPkg::pasidT act);
        if (act !== exp) abortRun($sformatf("FAILED at %0t: %s expected %h, got %h",
            $time, name, exp, act));
    endtask

    task automatic checkBdf(input string name, input devTlbPkg::bdfT exp,
                            input devTlbPkg::bdfT act);
        if (act !== exp) abortRun($sformatf("FAILED at %0t: %s expected %h, got %h",
            $time, name, exp, act));
    endtask

    task automatic checkReg(input string name, input devTlbPkg::regDataT exp,
                            input devTlbPkg::regDataT act);
        if (act !== exp) abortRun($sformatf("FAILED at %0t: %s expected %h, got %h",
            $time, name, exp, act));
    endtask

    // ========================================
    // Drivers
    // ========================================
    task automatic applyReset();
        clk = 1'b0;
        arstN = 1'b0;
        fillValid = 1'b0;
        fillGlobal = 1'b0;
        fillPasid = '0;
        fillBdf = '0;
        fillVpn = '0;
        fillPpn = '0;
        lookupValid = 1'b0;
        lookupPasid = '0;
        lookupBdf = '0;
        lookupVpn = '0;
        invValid = 1'b0;
        invPasid = '0;
        invPasidValid = 1'b0;
        invGlobal = 1'b0;
        invPriv = 1'b0;
        invBdf = '0;
        invBdfValid = 1'b0;
        drainReqAck = 1'b0;
        drainRspValid = 1'b0;
        drainRspTc = '0;
        regWrEn = 1'b0;
        regAddr = '0;
        regWrData = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            mValid[i] = 1'b0;
        end
        mVictim = 0;
        invIssued = 0;
        drainIssued = 0;
        lastTcExp = '0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
    endtask

    task automatic fillEntry(input devTlbPkg::pasidT pasid, input devTlbPkg::bdfT bdf,
                             input devTlbPkg::vpnT vpn, input devTlbPkg::ppnT ppn,
                             input logic glob);
        @(negedge clk);
        fillValid = 1'b1;
        fillPasid = pasid;
        fillBdf = bdf;
        fillVpn = vpn;
        fillPpn = ppn;
        fillGlobal = glob;
        @(negedge clk);
        fillValid = 1'b0;
        mValid[mVictim] = 1'b1;
        mGlobal[mVictim] = glob;
        mPasid[mVictim] = pasid;
        mBdf[mVictim] = bdf;
        mVpn[mVictim] = vpn;
        mPpn[mVictim] = ppn;
        mVictim = (mVictim + 1) % NUM_ENTRIES;
    endtask

    // Hit needs equal VPN and BDF, and an equal PASID or a global entry
    task automatic lookupCheck(input devTlbPkg::pasidT pasid, input devTlbPkg::bdfT bdf,
                               input devTlbPkg::vpnT vpn);
        logic           expHit;
        devTlbPkg::ppnT expPpn;
        expHit = 1'b0;
        expPpn = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!expHit && mValid[i] && mVpn[i] == vpn && mBdf[i] == bdf &&
                (mPasid[i] == pasid || mGlobal[i])) begin
                expHit = 1'b1;
                expPpn = mPpn[i];
            end
        end
        @(negedge clk);
        lookupValid = 1'b1;
        lookupPasid = pasid;
        lookupBdf = bdf;
        lookupVpn = vpn;
        @(negedge clk);
        lookupValid = 1'b0;
        checkBit("lookupDone", 1'b1, lookupDone);  // Exactly one cycle later
        checkBit("lookupHit", expHit, lookupHit);
        if (expHit) checkPpn("lookupPpn", expPpn, lookupPpn);
    endtask

    task automatic lookupEveryEntry();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            lookupCheck(mPasid[i], mBdf[i], mVpn[i]);
        end
    endtask

    // Invalidation match rule
    function automatic logic entryMatchesInv(input int i, input devTlbPkg::pasidT pasid,
        input logic pv, input logic glob, input devTlbPkg::bdfT bdf, input logic bv);
        logic bdfOk;
        logic pasidOk;
        bdfOk   = !bv || mBdf[i] == bdf;
        pasidOk = !pv || mPasid[i] == pasid;
        if (mGlobal[i] && mPasid[i] != pasid) pasidOk = glob;  // Global of another PASID
        return mValid[i] && bdfOk && pasidOk;
    endfunction

    task automatic issueInvalidation(input devTlbPkg::pasidT pasid, input logic pv,
        input logic glob, input logic priv, input devTlbPkg::bdfT bdf, input logic bv,
        input logic drainOn, input logic rspWithAck, input devTlbPkg::tcT tc);
        int cycles;
        int ackDelay;
        ackDelay = $unsigned($random(seed)) % 5;  // Host back-pressure
        @(negedge clk);
        invValid = 1'b1;
        invPasid = pasid;
        invPasidValid = pv;
        invGlobal = glob;
        invPriv = priv;
        invBdf = bdf;
        invBdfValid = bv;
        @(negedge clk);
        invValid = 1'b0;
        cycles   = 1;
        checkBit("invBusy", 1'b1, invBusy);
        // Walk ends on busy low or a drain request
        while (invBusy && !drainReqValid) begin
            if (cycles > 4 * NUM_ENTRIES) abortRun("Invalidation walk never ended");
            @(negedge clk);
            cycles++;
        end
        if (cycles != NUM_ENTRIES + 1) abortRun($sformatf(
            "Walk phase took %0d cycles instead of %0d", cycles, NUM_ENTRIES + 1));
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entryMatchesInv(i, pasid, pv, glob, bdf, bv)) mValid[i] = 1'b0;
        end
        invIssued++;
        if (!drainOn) begin
            checkBit("drainReqValid", 1'b0, drainReqValid);
            checkBit("invBusy", 1'b0, invBusy);
        end else begin
            checkBit("drainReqValid", 1'b1, drainReqValid);
            checkBit("invBusy", 1'b1, invBusy);
            checkPasid("drainReqPasid", pasid, drainReqPasid);
            checkBit("drainReqPasidValid", pv, drainReqPasidValid);
            checkBit("drainReqPriv", priv, drainReqPriv);
            checkBit("drainReqGlobal", glob, drainReqGlobal);
            checkBdf("drainReqBdf", bv ? bdf : 16'h0000, drainReqBdf);  // Zero if not valid
            checkBit("drainReqBdfValid", bv, drainReqBdfValid);
            repeat (ackDelay) begin
                @(negedge clk);
                checkBit("drainReqValid", 1'b1, drainReqValid);
            end
            drainReqAck = 1'b1;
            drainRspValid = rspWithAck;
            drainRspTc = tc;
            @(negedge clk);
            drainReqAck = 1'b0;
            drainRspValid = 1'b0;
            checkBit("drainReqValid", 1'b0, drainReqValid);
            if (!rspWithAck) begin
                repeat (ackDelay) begin
                    checkBit("invBusy", 1'b1, invBusy);
                    @(negedge clk);
                end
                checkBit("invBusy", 1'b1, invBusy);  // Still waiting for response
                drainRspValid = 1'b1;
                @(negedge clk);
                drainRspValid = 1'b0;
            end
            checkBit("invBusy", 1'b0, invBusy);
            drainIssued++;
            lastTcExp = tc;
        end
    endtask

    task automatic writeReg(input devTlbPkg::regAddrT addr, input devTlbPkg::regDataT data);
        @(negedge clk);
        regWrEn = 1'b1;
        regAddr = addr;
        regWrData = data;
        @(negedge clk);
        regWrEn = 1'b0;
    endtask

    task automatic expectReg(input devTlbPkg::regAddrT addr, input devTlbPkg::regDataT exp);
        @(negedge clk);
        regAddr = addr;
        @(negedge clk);
        checkReg($sformatf("regRdData[%0d]", addr), exp, regRdData);
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic resetState();
        @(negedge clk);
        checkBit("invBusy", 1'b0, invBusy);
        checkBit("drainReqValid", 1'b0, drainReqValid);
        checkBit("lookupDone", 1'b0, lookupDone);
        lookupCheck(20'h00001, BDF_A, 20'h01000);  // Empty array misses
        expectReg(2'd0, 32'd1);
        expectReg(2'd1, 32'd0);
        expectReg(2'd2, 32'd0);
        expectReg(2'd3, 32'd0);
    endtask

    task automatic fillAndLookup();
        devTlbPkg::ppnT ppn;
        pasA = devTlbPkg::pasidT'($random(seed));
        pasB = ~pasA;
        // Lower half under pasA, BDF alternates, entries 3 and 7 global
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            ppn = devTlbPkg::ppnT'($random(seed));
            fillEntry(i < NUM_ENTRIES / 2 ? pasA : pasB, i[0] ? BDF_B : BDF_A,
                      devTlbPkg::vpnT'(32'h1000 + i), ppn, (i % 4) == 3);
        end
        lookupEveryEntry();
        lookupCheck(mPasid[0], mBdf[0], mVpn[0] ^ 20'h00100);  // Other VPN
        lookupCheck(mPasid[1], mBdf[1] ^ 16'h0001, mVpn[1]);   // Other BDF
        lookupCheck(pasB, mBdf[3], mVpn[3]);                   // Global under pasB
        lookupCheck(pasB, mBdf[0], mVpn[0]);
    endtask

    task automatic invalidateNoDrain();
        writeReg(2'd0, 32'd0);
        issueInvalidation(pasA, 1'b1, 1'b0, 1'b0, BDF_A, 1'b0, 1'b0, 1'b0, 8'h00);
        lookupEveryEntry();
        // BDF only so globals of other PASIDs survive
        issueInvalidation(pasA ^ 20'h5, 1'b0, 1'b0, 1'b1, BDF_B, 1'b1, 1'b0, 1'b0, 8'h00);
        lookupEveryEntry();
        // invGlobal also takes the pasB global entry
        issueInvalidation(pasA, 1'b0, 1'b1, 1'b0, BDF_A, 1'b0, 1'b0, 1'b0, 8'h00);
        lookupEveryEntry();
    endtask

    task automatic drainHandshake();
        devTlbPkg::pasidT pasC;
        devTlbPkg::ppnT   ppn;
        writeReg(2'd0, 32'd1);
        pasC = devTlbPkg::pasidT'($random(seed));
        for (int i = 0; i < 4; i++) begin
            ppn = devTlbPkg::ppnT'($random(seed));
            fillEntry(i < 2 ? pasC : ~pasC, i[0] ? BDF_B : BDF_A,
                      devTlbPkg::vpnT'(32'h2000 + i), ppn, 1'b0);
        end
        lookupEveryEntry();
        // Response after the ack
        issueInvalidation(pasC, 1'b1, 1'b0, 1'b1, 16'h0300, 1'b0, 1'b1, 1'b0,
                          devTlbPkg::tcT'($random(seed)));
        lookupEveryEntry();
        // Response together with the ack
        issueInvalidation(~pasC, 1'b0, 1'b1, 1'b0, BDF_A, 1'b1, 1'b1, 1'b1,
                          devTlbPkg::tcT'($random(seed)));
        lookupEveryEntry();
    endtask

    task automatic registerCounts();
        expectReg(2'd1, devTlbPkg::regDataT'(invIssued));
        expectReg(2'd2, devTlbPkg::regDataT'(drainIssued));
        expectReg(2'd3, devTlbPkg::regDataT'(lastTcExp));
        writeReg(2'd1, 32'hFFFF_FFFF);  // Read-only index ignores the write
        writeReg(2'd2, 32'h0000_1234);
        writeReg(2'd3, 32'h0000_00A5);
        expectReg(2'd1, devTlbPkg::regDataT'(invIssued));
        expectReg(2'd2, devTlbPkg::regDataT'(drainIssued));
        expectReg(2'd3, devTlbPkg::regDataT'(lastTcExp));
        expectReg(2'd0, 32'd1);
    endtask

    initial begin
        seed = 5;
        applyReset();
        resetState();
        fillAndLookup();
        invalidateNoDrain();
        drainHandshake();
        registerCounts();
        $display("TEST OK");
        $finish;
    end

endmodule

/* all.f */
design/devTlbPkg.sv
design/tlbCache.sv
design/invDrain.sv
design/invCtrlRegs.sv
design/devTlbInv.sv
verif/devTlbInvTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the device TLB invalidation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module devTlbInvTb \
    --Mdir obj_dir -o devTlbInvSim > build.log 2>&1
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus, see build.log"
    exit 1
fi

./obj_dir/devTlbInvSim > sim.log 2>&1
simStatus=$?
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus, see sim.log"
fi

if grep -qx "TEST OK" sim.log && [ $simStatus -eq 0 ]; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
